// File: lcd_fb_cfg.svh
`ifndef LCD_FB_CFG_SVH
`define LCD_FB_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LCD_H_DISP      64              // pixels per line, multiple of 8 bursts.
`define LCD_V_DISP      4               // lines per frame.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// burst and queue sizing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LCD_BURST_LEN   16              // pixel words per burst.
`define LCD_NUM_BANKS   4               // bank write queues.
`define LCD_QUEUE_DEPTH 24              // words per queue, >= burst + header.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame buffer location
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define LCD_FB_BASE     32'h0000_0100   // pixel address of (0,0).

`endif

// File: lcd_fb_pkg.sv
package lcd_fb_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue word views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed
    {
        logic [23:0] addr;      // pixel address of first word.
        logic [7:0]  len;       // pixel words that follow.
    } burst_hdr_s;

    typedef struct packed
    {
        logic [7:0] pad;        // unused, kept zero.
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_s;

    // same 32 bits, decoded by the header flag beside it.
    typedef union packed
    {
        burst_hdr_s hdr;
        pixel_s     pix;
    } fb_word_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test pattern selection
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic
    {
        bars  = 1'b0,           // eight vertical bars.
        solid = 1'b1            // one color everywhere.
    } pattern_e;

    // left to right across the line.
    parameter logic [23:0] color_bar_rgb [8] = '{
        24'hFF0000,             // red.
        24'h00FF00,             // green.
        24'h0000FF,             // blue.
        24'hFFFFFF,             // white.
        24'h000000,             // black.
        24'hFFFF00,             // yellow.
        24'hFF00FF,             // magenta.
        24'h00FFFF              // cyan.
    };

endpackage

// File: pixel_pattern_gen.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module pixel_pattern_gen
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sys_valid,
    input  lcd_fb_pkg::pattern_e pattern_sel,
    input  logic [23:0]          solid_rgb,
    input  logic [7:0]           divide_param,
    input  logic                 gen_stall,
    output logic                 gen_valid,
    output lcd_fb_pkg::fb_word_u gen_word,
    output logic                 gen_hdr
);

localparam int xw    = $clog2(`LCD_H_DISP);
localparam int yw    = ($clog2(`LCD_V_DISP) > 0) ? $clog2(`LCD_V_DISP) : 1;
localparam int bw    = $clog2(`LCD_BURST_LEN);
localparam int bar_w = `LCD_H_DISP / 8;                 // pixels per color bar.

localparam logic [1:0] st_idle  = 2'd0;
localparam logic [1:0] st_hdr   = 2'd1;
localparam logic [1:0] st_pix   = 2'd2;
localparam logic [1:0] st_pause = 2'd3;

logic [1:0]    state;
logic [xw-1:0] x;                                       // column of next pixel.
logic [yw-1:0] y;                                       // current line.
logic [7:0]    pause_cnt;
logic [31:0]   hdr_addr;
logic [2:0]    bar_idx;
logic [23:0]   pix_rgb;
logic          accept;
logic          line_last;
logic          frame_last;
logic          burst_end;

assign accept     = gen_valid && !gen_stall;
assign line_last  = (x == xw'(`LCD_H_DISP - 1));
assign frame_last = line_last && (y == yw'(`LCD_V_DISP - 1));
assign burst_end  = &x[bw-1:0];                         // bursts are aligned in the line.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame walk
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        state     <= st_idle;
        x         <= '0;
        y         <= '0;
        pause_cnt <= '0;
    end
    else
    begin
        case (state)
            st_idle:
            begin
                if (sys_valid)
                    state <= st_hdr;
            end
            st_hdr:
            begin
                if (accept)
                    state <= st_pix;
            end
            st_pix:
            begin
                if (accept)
                begin
                    x <= line_last ? '0 : x + 1'b1;
                    if (line_last)
                        y <= frame_last ? '0 : y + 1'b1;
                    if (burst_end)
                    begin
                        pause_cnt <= '0;
                        if (divide_param != 8'd0)
                            state <= st_pause;
                        else if (sys_valid || !frame_last)
                            state <= st_hdr;    // a started frame always finishes.
                        else
                            state <= st_idle;
                    end
                end
            end
            st_pause:
            begin
                pause_cnt <= pause_cnt + 8'd1;
                if (pause_cnt == divide_param - 8'd1)
                    // x and y back at zero means the frame just ended.
                    state <= (sys_valid || x != '0 || y != '0) ? st_hdr : st_idle;
            end
            default:
            begin
                state <= st_idle;
            end
        endcase
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word build
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
assign hdr_addr = `LCD_FB_BASE + 32'(y) * 32'(`LCD_H_DISP) + 32'(x);
assign bar_idx  = 3'(x / xw'(bar_w));
assign pix_rgb  = (pattern_sel == lcd_fb_pkg::bars) ? lcd_fb_pkg::color_bar_rgb[bar_idx]
                                                    : solid_rgb;

assign gen_valid = (state == st_hdr) || (state == st_pix);
assign gen_hdr   = (state == st_hdr);

always_comb
begin
    gen_word = '0;
    if (state == st_hdr)
    begin
        gen_word.hdr.addr = hdr_addr[23:0];             // fits the 24-bit field.
        gen_word.hdr.len  = 8'(`LCD_BURST_LEN);
    end
    else
    begin
        gen_word.pix.red   = pix_rgb[23:16];
        gen_word.pix.green = pix_rgb[15:8];
        gen_word.pix.blue  = pix_rgb[7:0];
    end
end

endmodule

// File: burst_dispatch.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module burst_dispatch
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       gen_valid,
    input  lcd_fb_pkg::fb_word_u       gen_word,
    input  logic                       gen_hdr,
    input  logic [`LCD_NUM_BANKS-1:0]  credit_ret,
    output logic                       gen_stall,
    output logic [`LCD_NUM_BANKS-1:0]  push,
    output lcd_fb_pkg::fb_word_u       push_word,
    output logic                       push_hdr
);

localparam int bw = (`LCD_NUM_BANKS > 1) ? $clog2(`LCD_NUM_BANKS) : 1;
localparam int cw = $clog2(`LCD_QUEUE_DEPTH + 1);

logic [cw-1:0] credit [`LCD_NUM_BANKS];                 // free slots seen per bank.
logic [bw-1:0] cur;                                     // bank taking the next burst.
logic [7:0]    remain;                                  // pixels left, 0 between bursts.
logic          accept;

// a burst may only open once the bank can hold all of it.
assign gen_stall = (remain == 8'd0) && (credit[cur] < cw'(`LCD_BURST_LEN + 1));
assign accept    = gen_valid && !gen_stall;

assign push_word = gen_word;                            // straight through.
assign push_hdr  = gen_hdr;

always_comb
begin
    push      = '0;
    push[cur] = accept;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// burst tracking
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        cur    <= '0;
        remain <= '0;
    end
    else if (accept)
    begin
        if (gen_hdr)
            remain <= gen_word.hdr.len;
        else
        begin
            remain <= remain - 8'd1;
            if (remain == 8'd1)                         // last pixel, next bank.
                cur <= (cur == bw'(`LCD_NUM_BANKS - 1)) ? '0 : cur + 1'b1;
        end
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// credit counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        for (int k = 0; k < `LCD_NUM_BANKS; k++)
            credit[k] <= cw'(`LCD_QUEUE_DEPTH);
    end
    else
    begin
        for (int k = 0; k < `LCD_NUM_BANKS; k++)
            credit[k] <= credit[k] - cw'(push[k]) + cw'(credit_ret[k]);
    end
end

for (genvar k = 0; k < `LCD_NUM_BANKS; k++)
begin : g_credit_chk
    // returns from the queue never outrun the words sent to it.
    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credit[k] <= cw'(`LCD_QUEUE_DEPTH));
    // a push never lands on a bank with no slot left.
    a_credit_min: assert property (@(posedge clk) disable iff (!rst_n)
        push[k] |-> credit[k] != '0);
end

endmodule

// File: bank_write_queue.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module bank_write_queue
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  lcd_fb_pkg::fb_word_u push_word,
    input  logic                 push_hdr,
    input  logic                 pop,
    output logic                 q_nonempty,
    output lcd_fb_pkg::fb_word_u q_word,
    output logic                 q_hdr,
    output logic                 credit_ret
);

localparam int pw = $clog2(`LCD_QUEUE_DEPTH);
localparam int cw = $clog2(`LCD_QUEUE_DEPTH + 1);

logic [32:0]   mem [`LCD_QUEUE_DEPTH];                  // {hdr flag, word}.
logic [pw-1:0] wr_ptr;
logic [pw-1:0] rd_ptr;
logic [cw-1:0] count;
logic          full;
logic          do_push;
logic          do_pop;

assign full       = (count == cw'(`LCD_QUEUE_DEPTH));
assign q_nonempty = (count != '0);
assign do_push    = push && !full;
assign do_pop     = pop && q_nonempty;

// head of queue, read straight from storage.
assign q_word = mem[rd_ptr][31:0];
assign q_hdr  = mem[rd_ptr][32];

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// storage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk)
begin
    if (do_push)
        mem[wr_ptr] <= {push_hdr, push_word};
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pointers and credit return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        count      <= '0;
        credit_ret <= 1'b0;
    end
    else
    begin
        if (do_push)                                    // depth need not be a power of 2.
            wr_ptr <= (wr_ptr == pw'(`LCD_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (do_pop)
            rd_ptr <= (rd_ptr == pw'(`LCD_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count      <= count + cw'(do_push) - cw'(do_pop);
        credit_ret <= do_pop;                           // one slot freed per pop.
    end
end

// the dispatcher's credits must keep it off a full queue.
a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> !full);

// the arbiter only pops a bank it sees holding words.
a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> q_nonempty);

endmodule

// File: sdram_write_arbiter.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module sdram_write_arbiter
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`LCD_NUM_BANKS-1:0]  q_nonempty,
    input  lcd_fb_pkg::fb_word_u       q_word [`LCD_NUM_BANKS],
    input  logic [`LCD_NUM_BANKS-1:0]  q_hdr,
    input  logic                       mem_ready,
    output logic [`LCD_NUM_BANKS-1:0]  pop,
    output logic                       mem_load,
    output logic [31:0]                mem_addr,
    output logic [7:0]                 mem_len,
    output logic                       mem_we,
    output logic [23:0]                mem_data
);

localparam int bw = (`LCD_NUM_BANKS > 1) ? $clog2(`LCD_NUM_BANKS) : 1;

logic [bw-1:0]        cur;                              // bank being drained.
logic [7:0]           remain;                           // pixels left in its burst.
logic                 can_take;
logic                 take;
lcd_fb_pkg::fb_word_u out_word;                         // output payload register.

// output slot free, or it empties this cycle.
assign can_take = !(mem_load || mem_we) || mem_ready;
assign take     = can_take && q_nonempty[cur];

always_comb
begin
    pop      = '0;
    pop[cur] = take;
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank sequencing and strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always_ff @(posedge clk or negedge rst_n)
begin
    if (!rst_n)
    begin
        cur      <= '0;
        remain   <= '0;
        mem_load <= 1'b0;
        mem_we   <= 1'b0;
    end
    else if (take)
    begin
        mem_load <= q_hdr[cur];
        mem_we   <= !q_hdr[cur];
        if (q_hdr[cur])
            remain <= q_word[cur].hdr.len;
        else
        begin
            remain <= remain - 8'd1;
            if (remain == 8'd1)                         // burst done, rotate.
                cur <= (cur == bw'(`LCD_NUM_BANKS - 1)) ? '0 : cur + 1'b1;
        end
    end
    else if (can_take)
    begin
        mem_load <= 1'b0;                               // slot drained, nothing new.
        mem_we   <= 1'b0;
    end
end

always_ff @(posedge clk)
begin
    if (take)
        out_word <= q_word[cur];
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// union decode to the port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
assign mem_addr = {8'h00, out_word.hdr.addr};
assign mem_len  = out_word.hdr.len;
assign mem_data = {out_word.pix.red, out_word.pix.green, out_word.pix.blue};

a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_load && mem_we));

// a waiting transfer keeps its strobe and every field.
a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_load || mem_we) && !mem_ready
    |=> $stable({mem_load, mem_we, mem_addr, mem_len, mem_data}));

endmodule

// File: lcd_fb_writer_top.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module lcd_fb_writer_top
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 sys_valid,
    input  lcd_fb_pkg::pattern_e pattern_sel,
    input  logic [23:0]          solid_rgb,
    input  logic [7:0]           divide_param,
    input  logic                 mem_ready,
    output logic                 mem_load,
    output logic [31:0]          mem_addr,
    output logic [7:0]           mem_len,
    output logic                 mem_we,
    output logic [23:0]          mem_data
);

logic                       gen_valid;
logic                       gen_hdr;
logic                       gen_stall;
lcd_fb_pkg::fb_word_u       gen_word;
logic [`LCD_NUM_BANKS-1:0]  push;                       // one per bank queue.
logic                       push_hdr;
lcd_fb_pkg::fb_word_u       push_word;
logic [`LCD_NUM_BANKS-1:0]  credit_ret;
logic [`LCD_NUM_BANKS-1:0]  q_nonempty;
logic [`LCD_NUM_BANKS-1:0]  q_hdr;
lcd_fb_pkg::fb_word_u       q_word [`LCD_NUM_BANKS];
logic [`LCD_NUM_BANKS-1:0]  pop;

pixel_pattern_gen gen_i
(
    .clk          (clk),
    .rst_n        (rst_n),
    .sys_valid    (sys_valid),
    .pattern_sel  (pattern_sel),
    .solid_rgb    (solid_rgb),
    .divide_param (divide_param),
    .gen_stall    (gen_stall),
    .gen_valid    (gen_valid),
    .gen_word     (gen_word),
    .gen_hdr      (gen_hdr)
);

burst_dispatch dispatch_i
(
    .clk        (clk),
    .rst_n      (rst_n),
    .gen_valid  (gen_valid),
    .gen_word   (gen_word),
    .gen_hdr    (gen_hdr),
    .credit_ret (credit_ret),
    .gen_stall  (gen_stall),
    .push       (push),
    .push_word  (push_word),
    .push_hdr   (push_hdr)
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank queues
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
for (genvar k = 0; k < `LCD_NUM_BANKS; k++)
begin : g_bank
    bank_write_queue queue_i
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push[k]),
        .push_word  (push_word),                        // shared, push[k] selects.
        .push_hdr   (push_hdr),
        .pop        (pop[k]),
        .q_nonempty (q_nonempty[k]),
        .q_word     (q_word[k]),
        .q_hdr      (q_hdr[k]),
        .credit_ret (credit_ret[k])
    );
end

sdram_write_arbiter arbiter_i
(
    .clk        (clk),
    .rst_n      (rst_n),
    .q_nonempty (q_nonempty),
    .q_word     (q_word),
    .q_hdr      (q_hdr),
    .mem_ready  (mem_ready),
    .pop        (pop),
    .mem_load   (mem_load),
    .mem_addr   (mem_addr),
    .mem_len    (mem_len),
    .mem_we     (mem_we),
    .mem_data   (mem_data)
);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    input  logic reset_req,
    output logic clk,
    output logic rst_n
);

localparam real half_period = 4.0;                      // 8 ns clock.

int hold;                                               // reset cycles still to run.

initial
begin
    clk   = 1'b0;
    rst_n = 1'b0;
    hold  = 4;
end

always #(half_period) clk = ~clk;

// a request restarts the 4-cycle reset.
always @(posedge clk)
begin
    if (reset_req)
    begin
        hold  <= 4;
        rst_n <= 1'b0;
    end
    else if (hold > 1)
        hold <= hold - 1;
    else
    begin
        hold  <= 0;
        rst_n <= 1'b1;
    end
end

endmodule

// File: lcd_fb_checker.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module lcd_fb_checker
(
    input logic        clk,
    input logic        rst_n,
    input logic        mem_ready,
    input logic        mem_load,
    input logic [31:0] mem_addr,
    input logic [7:0]  mem_len,
    input logic        mem_we,
    input logic [23:0] mem_data
);

localparam int burst_words     = `LCD_BURST_LEN + 1;   // header plus pixels.
localparam int bursts_per_line = `LCD_H_DISP / `LCD_BURST_LEN;
localparam int frame_words     = `LCD_V_DISP * bursts_per_line * burst_words;
localparam int bar_width       = `LCD_H_DISP / 8;      // eight bars per line.

int          words_seen;                                // transfers in this test.
int          frames_started;                            // headers at the frame base.
string       test_name;
logic        use_solid;
logic [23:0] solid_color;
int          total_words;                               // frames times frame size.
string       fail_text;                                 // first failure, empty if none.
int          tests_run = 0;
int          tests_failed = 0;
int          words_checked = 0;

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference colors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
function automatic logic [23:0] bar_rgb(input int bar);
    case (bar)
        0:       return 24'hFF0000;                     // red.
        1:       return 24'h00FF00;                     // green.
        2:       return 24'h0000FF;                     // blue.
        3:       return 24'hFFFFFF;                     // white.
        4:       return 24'h000000;                     // black.
        5:       return 24'hFFFF00;                     // yellow.
        6:       return 24'hFF00FF;                     // magenta.
        default: return 24'h00FFFF;                     // cyan.
    endcase
endfunction

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-transfer compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge clk)
begin : sample
    int          pos;
    int          burst;
    int          slot;
    int          x0;
    int          y;
    logic [31:0] exp_addr;
    logic [23:0] exp_pix;
    string       msg;
    msg = "";
    if (!rst_n)
    begin
        words_seen     <= 0;
        frames_started <= 0;
        fail_text       = "";
    end
    else
    begin
        if (mem_load && mem_we)
            msg = $sformatf("%s: mem_load and mem_we were high in the same cycle", test_name);
        if (mem_ready && (mem_load || mem_we))
        begin
            pos   = words_seen % frame_words;          // wraps every frame.
            burst = pos / burst_words;
            slot  = pos % burst_words;                  // 0 is the header.
            y     = burst / bursts_per_line;
            x0    = (burst % bursts_per_line) * `LCD_BURST_LEN;
            words_seen <= words_seen + 1;
            if (mem_load && mem_addr == `LCD_FB_BASE)
                frames_started <= frames_started + 1;
            if (words_seen >= total_words)
                msg = $sformatf("%s: extra transfer after the last expected word", test_name);
            else if (slot == 0)
            begin
                exp_addr = `LCD_FB_BASE + 32'(y * `LCD_H_DISP + x0);
                if (!mem_load)
                    msg = $sformatf("%s: pixel written where burst header %0d was due",
                                    test_name, words_seen);
                else if (mem_addr != exp_addr || mem_len != 8'(`LCD_BURST_LEN))
                    msg = $sformatf("Error %s: word %0d expected addr %h len %0d, actual addr %h len %0d",
                                    test_name, words_seen, exp_addr, `LCD_BURST_LEN,
                                    mem_addr, mem_len);
            end
            else
            begin
                exp_pix = use_solid ? solid_color : bar_rgb((x0 + slot - 1) / bar_width);
                if (!mem_we)
                    msg = $sformatf("%s: burst header written where pixel %0d was due",
                                    test_name, words_seen);
                else if (mem_data != exp_pix)
                    msg = $sformatf("Error %s: word %0d expected %h, actual %h",
                                    test_name, words_seen, exp_pix, mem_data);
            end
        end
        if (msg != "" && fail_text == "")
            fail_text = msg;                            // keep the first only.
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test bookkeeping
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic start_test(input string name, input logic solid, input logic [23:0] rgb,
                          input int words);
    test_name   = name;
    use_solid   = solid;
    solid_color = rgb;
    total_words = words;
endtask

task automatic finish_test();
    tests_run++;
    words_checked += words_seen;
    if (fail_text != "")
    begin
        tests_failed++;
        $display("%s", fail_text);
    end
    else if (words_seen < total_words)
    begin
        tests_failed++;
        $display("%s: only %0d of %0d words reached the memory port",
                 test_name, words_seen, total_words);
    end
    else
        $display("%s: %0d words over %0d frames matched", test_name, words_seen, frames_started);
endtask

task automatic report_counts();
    $display("%0d tests run, %0d passed, %0d failed, %0d words compared",
             tests_run, tests_run - tests_failed, tests_failed, words_checked);
endtask

endmodule

// File: lcd_fb_tb.sv
`timescale 1ns/1ps
`include "lcd_fb_cfg.svh"

module lcd_fb_tb;

localparam int burst_words      = `LCD_BURST_LEN + 1;
localparam int bursts_per_frame = `LCD_V_DISP * `LCD_H_DISP / `LCD_BURST_LEN;
localparam int frame_words      = bursts_per_frame * burst_words;
localparam int drain_cycles     = 64;                   // quiet time to expose extra writes.
localparam int start_overhead   = 200;                  // reset and pipeline fill.

logic                 clk;
logic                 rst_n;
logic                 reset_req;
logic                 sys_valid;
lcd_fb_pkg::pattern_e pattern_sel;
logic [23:0]          solid_rgb;
logic [7:0]           divide_param;
logic                 mem_ready;
logic                 mem_load;
logic [31:0]          mem_addr;
logic [7:0]           mem_len;
logic                 mem_we;
logic [23:0]          mem_data;

int   ready_pct;                                        // mem_ready odds in percent.
int   cycle_now;
int   test_start;
int   cycle_limit;
logic test_active;

tb_clock_gen clk_gen_i
(
    .reset_req (reset_req),
    .clk       (clk),
    .rst_n     (rst_n)
);

lcd_fb_writer_top dut_i
(
    .clk          (clk),
    .rst_n        (rst_n),
    .sys_valid    (sys_valid),
    .pattern_sel  (pattern_sel),
    .solid_rgb    (solid_rgb),
    .divide_param (divide_param),
    .mem_ready    (mem_ready),
    .mem_load     (mem_load),
    .mem_addr     (mem_addr),
    .mem_len      (mem_len),
    .mem_we       (mem_we),
    .mem_data     (mem_data)
);

lcd_fb_checker checker_i
(
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_ready (mem_ready),
    .mem_load  (mem_load),
    .mem_addr  (mem_addr),
    .mem_len   (mem_len),
    .mem_we    (mem_we),
    .mem_data  (mem_data)
);

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory side and watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
always @(posedge clk)
begin
    cycle_now <= cycle_now + 1;
    mem_ready <= ($urandom % 100) < ready_pct;          // new draw every cycle.
end

always @(posedge clk)
begin
    if (test_active && (cycle_now - test_start > cycle_limit))
    begin
        $display("watchdog: test still running after %0d cycles", cycle_limit);
        $display("CHECKS FAILED");
        $finish;
    end
end

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one test from the file
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
task automatic run_test(input string name, input string pat, input logic [23:0] rgb,
                        input int pause, input int pct, input int frames);
    int   total;
    int   limit;
    logic solid;
    solid = (pat == "solid");
    total = frames * frame_words;
    limit = frames * (frame_words + bursts_per_frame * pause) * 100
            / ((pct > 0) ? pct : 1) * 4 + start_overhead + drain_cycles;
    @(posedge clk);
    reset_req    <= 1'b1;
    sys_valid    <= 1'b0;
    pattern_sel  <= solid ? lcd_fb_pkg::solid : lcd_fb_pkg::bars;
    solid_rgb    <= rgb;
    divide_param <= 8'(pause);
    ready_pct    <= pct;
    @(posedge clk);
    reset_req   <= 1'b0;
    test_start  <= cycle_now;
    cycle_limit <= limit;
    test_active <= 1'b1;
    checker_i.start_test(name, solid, rgb, total);
    @(posedge clk);
    while (!rst_n)
        @(posedge clk);
    sys_valid <= 1'b1;
    while (checker_i.frames_started < frames)           // last frame has begun.
        @(posedge clk);
    sys_valid <= 1'b0;                                  // that frame still completes.
    while (checker_i.words_seen < total)
        @(posedge clk);
    repeat (drain_cycles)
        @(posedge clk);
    test_active <= 1'b0;
    checker_i.finish_test();
endtask

initial
begin : main
    int          fd;
    int          n;
    string       line;
    string       name;
    string       pat;
    logic [23:0] rgb;
    int          pause;
    int          pct;
    int          frames;
    int unsigned seed;
    int unsigned first;
    sys_valid    = 1'b0;
    pattern_sel  = lcd_fb_pkg::bars;
    solid_rgb    = 24'h0;
    divide_param = 8'd0;
    mem_ready    = 1'b0;
    reset_req    = 1'b0;
    ready_pct    = 100;
    cycle_now    = 0;
    test_start   = 0;
    cycle_limit  = 0;
    test_active  = 1'b0;
    seed         = 32'h33d6_cd65;
    first        = $urandom(seed);                      // seeds the generator once.
    fd = $fopen("lcd_fb_stimulus.txt", "r");
    if (fd == 0)
    begin
        $display("stimulus file lcd_fb_stimulus.txt could not be opened");
        $display("CHECKS FAILED");
        $finish;
    end
    else
    begin
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#")           // skip blanks and column notes.
            begin
                n = $sscanf(line, "%s %s %h %d %d %d", name, pat, rgb, pause, pct, frames);
                if (n == 6)
                    run_test(name, pat, rgb, pause, pct, frames);
            end
        end
        $fclose(fd);
        checker_i.report_counts();
        if (checker_i.tests_failed == 0 && checker_i.tests_run > 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end
end

endmodule

// File: lcd_fb_stimulus.txt
# columns: name pattern(bars|solid) solid_rgb(hex) pause ready_pct frames
# expected stream follows from pattern, solid_rgb and frames
bars_full_ready    bars  000000 0 100 1
solid_full_ready   solid 3a7bc4 0 100 1
bars_ready_30      bars  000000 0 30  1
solid_ready_30     solid c0ffee 0 30  1
bars_pause_5       bars  000000 5 100 1
solid_pause_3      solid 5a5a5a 3 60  1
bars_multi_frame   bars  000000 2 70  3
solid_multi_frame  solid 123456 0 100 2

// File: filelist.f
+incdir+.
lcd_fb_pkg.sv
pixel_pattern_gen.sv
burst_dispatch.sv
bank_write_queue.sv
sdram_write_arbiter.sv
lcd_fb_writer_top.sv
tb_clock_gen.sv
lcd_fb_checker.sv
lcd_fb_tb.sv
